/* tb.f */
verilog/shell_pkg.sv
verilog/regs_pkg.sv
verilog/shell_regs.sv
verilog/packet_dispatch.sv
verilog/stream_fifo.sv
verilog/partition_decoupler.sv
verilog/return_arbiter.sv
verilog/rp_shell.sv
testbench/tb_partition_model.sv
testbench/tb_rp_shell.sv

/* run.sh */
#!/bin/sh
# Build and run the rp_shell testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_rp_shell -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_rp_shell)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

/* testbench/tb_rp_shell.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rp_shell;

  import shell_pkg::*;
  import regs_pkg::*;

  logic                     clk;
  logic                     arst_n;
  logic [data_w-1:0]        s_tdata;
  logic                     s_tvalid;
  logic                     s_tready;
  logic                     s_tlast;
  logic [data_w-1:0]        m_tdata;
  logic                     m_tvalid;
  logic                     m_tready;
  logic                     m_tlast;
  logic [rp_num*data_w-1:0] rp_tx_tdata;
  logic [rp_num-1:0]        rp_tx_tvalid;
  logic [rp_num-1:0]        rp_tx_tready;
  logic [rp_num-1:0]        rp_tx_tlast;
  logic [rp_num*data_w-1:0] rp_rx_tdata;
  logic [rp_num-1:0]        rp_rx_tvalid;
  logic [rp_num-1:0]        rp_rx_tready;
  logic [rp_num-1:0]        rp_rx_tlast;
  logic                     cfg_wr;
  logic [cfg_addr_w-1:0]    cfg_addr;
  logic [cfg_data_w-1:0]    cfg_wdata;

  logic [31:0]              rnd;
  logic [2*rp_num-1:0]      pace;
  logic [rp_num-1:0]        ret_en;
  logic                     iso_chk;
  logic                     out_busy;
  logic [rp_idx_w-1:0]      out_tag;
  string                    test_name;
  int                       mismatches = 0;
  int                       faults = 0;
  int                       seq;

  // Expected beats per lane and per returning tag, tlast in the top bit
  logic [data_w:0]          lane_exp [rp_num][$];
  logic [data_w:0]          out_exp  [rp_num][$];

  rp_shell u_dut (
    .axis_aclk    (clk),
    .arst_n       (arst_n),
    .s_tdata      (s_tdata),
    .s_tvalid     (s_tvalid),
    .s_tready     (s_tready),
    .s_tlast      (s_tlast),
    .m_tdata      (m_tdata),
    .m_tvalid     (m_tvalid),
    .m_tready     (m_tready),
    .m_tlast      (m_tlast),
    .rp_tx_tdata  (rp_tx_tdata),
    .rp_tx_tvalid (rp_tx_tvalid),
    .rp_tx_tready (rp_tx_tready),
    .rp_tx_tlast  (rp_tx_tlast),
    .rp_rx_tdata  (rp_rx_tdata),
    .rp_rx_tvalid (rp_rx_tvalid),
    .rp_rx_tready (rp_rx_tready),
    .rp_rx_tlast  (rp_rx_tlast),
    .cfg_wr       (cfg_wr),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata)
  );

  for (genvar i = 0; i < rp_num; i++) begin : g_model
    tb_partition_model u_model (
      .clk       (clk),
      .arst_n    (arst_n),
      .idx       (rp_idx_w'(i)),
      .pace      (pace[2*i +: 2]),
      .ret_en    (ret_en[i]),
      .tx_tdata  (rp_tx_tdata[i*data_w +: data_w]),
      .tx_tvalid (rp_tx_tvalid[i]),
      .tx_tlast  (rp_tx_tlast[i]),
      .tx_tready (rp_tx_tready[i]),
      .rx_tdata  (rp_rx_tdata[i*data_w +: data_w]),
      .rx_tvalid (rp_rx_tvalid[i]),
      .rx_tlast  (rp_rx_tlast[i]),
      .rx_tready (rp_rx_tready[i])
    );
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int pending(input bit with_out);
    int n;
    n = 0;
    for (int i = 0; i < rp_num; i++) begin
      n += lane_exp[i].size();
      // Partition 1 returns are held back while isolated
      if (with_out && !(iso_chk && i == 1)) begin
        n += out_exp[i].size();
      end
    end
    return n;
  endfunction

  function automatic void check_beat(input logic [data_w:0] want, input logic [data_w:0] got);
    assert (got == want) else begin
      mismatches++;
      $display("Mismatch in %s: expected %h, actual %h", test_name, want, got);
    end
  endfunction

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // Ready and pacing for models and output
  initial begin
    rnd      = 32'd49;
    pace     = '0;
    m_tready = 1'b0;
    forever begin
      @(negedge clk);
      rnd      = xorshift(rnd);
      pace     = rnd[2*rp_num-1:0];
      m_tready = rnd[8] | rnd[9];
    end
  end

  always @(posedge clk) begin : scoreboard
    logic [data_w:0] got;
    logic [data_w:0] want;
    beat_u           ob;
    if (!arst_n) begin
      out_busy = 1'b0;
      out_tag  = '0;
    end else begin
      for (int i = 0; i < rp_num; i++) begin
        if (rp_tx_tvalid[i] && rp_tx_tready[i]) begin
          got = {rp_tx_tlast[i], rp_tx_tdata[i*data_w +: data_w]};
          assert (lane_exp[i].size() > 0) else begin
            faults++;
            $display("Lane %0d received a beat in %s that was not routed to it", i, test_name);
          end
          if (lane_exp[i].size() > 0) begin
            want = lane_exp[i].pop_front();
            check_beat(want, got);
          end
        end
      end
      if (m_tvalid && m_tready) begin
        got    = {m_tlast, m_tdata};
        ob.raw = m_tdata;
        if (!out_busy) begin
          assert (ob.hdr.src_tag < tag_w'(rp_num)) else begin
            faults++;
            $display("Output packet in %s carries unknown tag %0d", test_name, ob.hdr.src_tag);
          end
          out_tag = ob.hdr.src_tag[rp_idx_w-1:0];
          assert (!(iso_chk && out_tag == 1)) else begin
            faults++;
            $display("Partition 1 return reached the output while decoupled");
          end
        end
        assert (out_exp[out_tag].size() > 0) else begin
          faults++;
          $display("Output beat in %s with no packet expected from tag %0d", test_name, out_tag);
        end
        if (out_exp[out_tag].size() > 0) begin
          want = out_exp[out_tag].pop_front();
          check_beat(want, got);
        end
        out_busy = !m_tlast;
      end
    end
  end

  a_tx_isolated: assert property (@(posedge clk) disable iff (!arst_n)
    iso_chk |-> !rp_tx_tvalid[1])
    else begin
      faults++;
      $display("Partition 1 was offered a beat while decoupled");
    end

  a_rx_isolated: assert property (@(posedge clk) disable iff (!arst_n)
    iso_chk |-> !rp_rx_tready[1])
    else begin
      faults++;
      $display("Partition 1 return was accepted while decoupled");
    end

  task automatic wait_ready();
    int n;
    n = 0;
    @(posedge clk);
    while (!s_tready && n < 500) begin
      n++;
      @(posedge clk);
    end
    if (!s_tready) begin
      faults++;
      $display("Timed out waiting for ingress ready in %s", test_name);
    end
  endtask

  task automatic wait_drain(input bit with_out);
    int n;
    n = 0;
    while (pending(with_out) != 0 && n < 5000) begin
      n++;
      @(negedge clk);
    end
    if (pending(with_out) != 0) begin
      faults++;
      $display("Timed out in %s with %0d beats still expected", test_name, pending(with_out));
    end
  endtask

  // Negative lane means the packet must be discarded
  task automatic send_pkt(input logic [port_w-1:0] port, input int len, input int lane);
    beat_u b;
    beat_u r;
    for (int k = 0; k < len; k++) begin
      if (k == 0) begin
        b.hdr.dest_port = port;
        b.hdr.src_tag   = tag_w'(seq);
      end else begin
        b.raw = {8'hc3, 8'(seq), 16'(k)};
      end
      r = b;
      if (k == 0) begin
        r.hdr.src_tag = tag_w'(lane);
      end
      if (lane >= 0) begin
        lane_exp[lane].push_back({k == len - 1, b.raw});
        out_exp[lane].push_back({k == len - 1, r.raw});
      end
      @(negedge clk);
      s_tdata  = b.raw;
      s_tlast  = (k == len - 1);
      s_tvalid = 1'b1;
      wait_ready();
    end
    @(negedge clk);
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    seq++;
  endtask

  task automatic cfg_write(input logic [cfg_addr_w-1:0] addr, input logic [cfg_data_w-1:0] data);
    @(negedge clk);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_wr    = 1'b0;
  endtask

  initial begin
    arst_n    = 1'b0;
    s_tdata   = '0;
    s_tvalid  = 1'b0;
    s_tlast   = 1'b0;
    cfg_wr    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    ret_en    = '1;
    iso_chk   = 1'b0;
    seq       = 0;
    test_name = "reset";
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    test_name = "routing";
    for (int i = 0; i < rp_num; i++) begin
      send_pkt(port_base + 16'(i), 2 + i, i);
    end
    send_pkt(port_base + 16'd3, 1, 3);
    send_pkt(port_base, 5, 0);
    wait_drain(1'b1);

    test_name = "discard";
    send_pkt(16'd999, 4, -1);
    send_pkt(port_base + 16'd1, 3, 1);
    wait_drain(1'b1);

    test_name = "reprogram";
    cfg_write(addr_port2, 16'd5002);
    send_pkt(16'd5002, 3, 2);
    send_pkt(port_base + 16'd2, 3, -1);
    send_pkt(16'd5002, 2, 2);
    wait_drain(1'b1);

    // Partition 1 holds one packet back across the decoupled window
    test_name = "decouple";
    ret_en[1] = 1'b0;
    send_pkt(port_base + 16'd1, 3, 1);
    wait_drain(1'b0);
    cfg_write(addr_decouple, 16'h0002);
    repeat (2) @(negedge clk);
    iso_chk   = 1'b1;
    ret_en[1] = 1'b1;
    send_pkt(port_base + 16'd1, 4, -1);
    send_pkt(port_base, 2, 0);
    wait_drain(1'b1);
    repeat (30) @(negedge clk);
    iso_chk = 1'b0;
    cfg_write(addr_decouple, 16'h0000);
    repeat (2) @(negedge clk);
    send_pkt(port_base + 16'd1, 3, 1);
    wait_drain(1'b1);

    // All partitions release their returns together
    test_name = "merge";
    @(negedge clk);
    ret_en = '0;
    for (int n = 0; n < 4; n++) begin
      for (int i = 0; i < rp_num; i++) begin
        send_pkt(i == 2 ? 16'd5002 : port_base + 16'(i), 1 + (n + i) % 4, i);
      end
    end
    wait_drain(1'b0);
    @(negedge clk);
    ret_en = '1;
    wait_drain(1'b1);

    assert (pending(1'b1) == 0) else begin
      faults++;
      $display("Some expected beats were never delivered");
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatches, faults);
    if (mismatches == 0 && faults == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/tb_partition_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_partition_model (
  input  wire                            clk,
  input  wire                            arst_n,
  input  wire  [shell_pkg::rp_idx_w-1:0] idx,
  input  wire  [1:0]                     pace,
  input  wire                            ret_en,
  input  wire  [shell_pkg::data_w-1:0]   tx_tdata,
  input  wire                            tx_tvalid,
  input  wire                            tx_tlast,
  output logic                           tx_tready,
  output logic [shell_pkg::data_w-1:0]   rx_tdata,
  output logic                           rx_tvalid,
  output logic                           rx_tlast,
  input  wire                            rx_tready
);

  import shell_pkg::*;

  // Beats waiting to go back, tlast in the top bit
  logic [data_w:0] ret_q [$];
  logic            first;
  logic            fired;
  logic            en;
  logic [1:0]      pc;
  beat_u           b;

  initial begin
    tx_tready = 1'b0;
    rx_tvalid = 1'b0;
    rx_tdata  = '0;
    rx_tlast  = 1'b0;
    first     = 1'b1;
    forever begin
      @(posedge clk);
      pc    = pace;
      en    = ret_en;
      fired = rx_tvalid && rx_tready;
      if (fired) begin
        void'(ret_q.pop_front());
      end
      if (tx_tvalid && tx_tready) begin
        b.raw = tx_tdata;
        // Header goes back with this partition's tag
        if (first) begin
          b.hdr.src_tag = tag_w'(idx);
        end
        ret_q.push_back({tx_tlast, b.raw});
        first = tx_tlast;
      end
      @(negedge clk);
      tx_tready = arst_n && pc[0];
      // An offered beat stays put until taken
      if (!rx_tvalid || fired) begin
        rx_tvalid = arst_n && en && (ret_q.size() > 0) && pc[1];
        if (ret_q.size() > 0) begin
          {rx_tlast, rx_tdata} = ret_q[0];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/rp_shell.sv */
`timescale 1ns/1ps
`default_nettype none

module rp_shell (
  input  wire                                             axis_aclk,
  input  wire                                             arst_n,
  input  wire  [shell_pkg::data_w-1:0]                    s_tdata,
  input  wire                                             s_tvalid,
  output wire                                             s_tready,
  input  wire                                             s_tlast,
  output wire  [shell_pkg::data_w-1:0]                    m_tdata,
  output wire                                             m_tvalid,
  input  wire                                             m_tready,
  output wire                                             m_tlast,
  output wire  [shell_pkg::rp_num*shell_pkg::data_w-1:0] rp_tx_tdata,
  output wire  [shell_pkg::rp_num-1:0]                   rp_tx_tvalid,
  input  wire  [shell_pkg::rp_num-1:0]                   rp_tx_tready,
  output wire  [shell_pkg::rp_num-1:0]                   rp_tx_tlast,
  input  wire  [shell_pkg::rp_num*shell_pkg::data_w-1:0] rp_rx_tdata,
  input  wire  [shell_pkg::rp_num-1:0]                   rp_rx_tvalid,
  output wire  [shell_pkg::rp_num-1:0]                   rp_rx_tready,
  input  wire  [shell_pkg::rp_num-1:0]                   rp_rx_tlast,
  input  wire                                             cfg_wr,
  input  wire  [regs_pkg::cfg_addr_w-1:0]                 cfg_addr,
  input  wire  [regs_pkg::cfg_data_w-1:0]                 cfg_wdata
);

  import shell_pkg::*;

  wire [rp_num*port_w-1:0] port_num;
  wire [rp_num-1:0]        decouple;

  // Dispatcher to FIFO
  wire [rp_num*data_w-1:0] lane_tdata;
  wire [rp_num-1:0]        lane_tvalid;
  wire [rp_num-1:0]        lane_tready;
  wire [rp_num-1:0]        lane_tlast;

  // FIFO to decoupler
  wire [rp_num*data_w-1:0] sh_tdata;
  wire [rp_num-1:0]        sh_tvalid;
  wire [rp_num-1:0]        sh_tready;
  wire [rp_num-1:0]        sh_tlast;

  // Decoupler to arbiter
  wire [rp_num*data_w-1:0] ret_tdata;
  wire [rp_num-1:0]        ret_tvalid;
  wire [rp_num-1:0]        ret_tready;
  wire [rp_num-1:0]        ret_tlast;

  shell_regs u_regs (
    .axis_aclk (axis_aclk),
    .arst_n    (arst_n),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .port_num  (port_num),
    .decouple  (decouple)
  );

  packet_dispatch u_dispatch (
    .axis_aclk   (axis_aclk),
    .arst_n      (arst_n),
    .s_tdata     (s_tdata),
    .s_tvalid    (s_tvalid),
    .s_tlast     (s_tlast),
    .s_tready    (s_tready),
    .port_num    (port_num),
    .lane_tdata  (lane_tdata),
    .lane_tvalid (lane_tvalid),
    .lane_tlast  (lane_tlast),
    .lane_tready (lane_tready)
  );

  for (genvar i = 0; i < rp_num; i++) begin : g_rp
    stream_fifo u_fifo (
      .axis_aclk  (axis_aclk),
      .arst_n     (arst_n),
      .in_tdata   (lane_tdata[i*data_w +: data_w]),
      .in_tvalid  (lane_tvalid[i]),
      .in_tlast   (lane_tlast[i]),
      .in_tready  (lane_tready[i]),
      .out_tdata  (sh_tdata[i*data_w +: data_w]),
      .out_tvalid (sh_tvalid[i]),
      .out_tlast  (sh_tlast[i]),
      .out_tready (sh_tready[i])
    );

    partition_decoupler u_decoupler (
      .axis_aclk    (axis_aclk),
      .arst_n       (arst_n),
      .decouple     (decouple[i]),
      .sh_tdata     (sh_tdata[i*data_w +: data_w]),
      .sh_tvalid    (sh_tvalid[i]),
      .sh_tlast     (sh_tlast[i]),
      .sh_tready    (sh_tready[i]),
      .rp_tx_tdata  (rp_tx_tdata[i*data_w +: data_w]),
      .rp_tx_tvalid (rp_tx_tvalid[i]),
      .rp_tx_tlast  (rp_tx_tlast[i]),
      .rp_tx_tready (rp_tx_tready[i]),
      .rp_rx_tdata  (rp_rx_tdata[i*data_w +: data_w]),
      .rp_rx_tvalid (rp_rx_tvalid[i]),
      .rp_rx_tlast  (rp_rx_tlast[i]),
      .rp_rx_tready (rp_rx_tready[i]),
      .ret_tdata    (ret_tdata[i*data_w +: data_w]),
      .ret_tvalid   (ret_tvalid[i]),
      .ret_tlast    (ret_tlast[i]),
      .ret_tready   (ret_tready[i])
    );
  end

  return_arbiter u_arbiter (
    .axis_aclk (axis_aclk),
    .arst_n    (arst_n),
    .in_tdata  (ret_tdata),
    .in_tvalid (ret_tvalid),
    .in_tlast  (ret_tlast),
    .in_tready (ret_tready),
    .m_tdata   (m_tdata),
    .m_tvalid  (m_tvalid),
    .m_tlast   (m_tlast),
    .m_tready  (m_tready)
  );

endmodule

`default_nettype wire

/* verilog/return_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module return_arbiter (
  input  wire                                             axis_aclk,
  input  wire                                             arst_n,
  input  wire  [shell_pkg::rp_num*shell_pkg::data_w-1:0] in_tdata,
  input  wire  [shell_pkg::rp_num-1:0]                   in_tvalid,
  input  wire  [shell_pkg::rp_num-1:0]                   in_tlast,
  output logic [shell_pkg::rp_num-1:0]                   in_tready,
  output logic [shell_pkg::data_w-1:0]                   m_tdata,
  output logic                                            m_tvalid,
  output logic                                            m_tlast,
  input  wire                                             m_tready
);

  import shell_pkg::*;

  logic [rp_idx_w-1:0] rr_idx;
  logic                lock;
  logic                pick_hit;
  logic [rp_idx_w-1:0] pick_idx;
  logic [rp_idx_w-1:0] cur_idx;
  logic [rp_num-1:0]   grant;
  logic                load_ok;
  logic                xfer;
  beat_u               out_beat;

  // Search starts one past the last granted lane
  always_comb begin
    logic [rp_idx_w-1:0] cand;
    pick_hit = 1'b0;
    pick_idx = rr_idx;
    for (int k = rp_num; k >= 1; k--) begin
      cand = rr_idx + rp_idx_w'(k);
      if (in_tvalid[cand]) begin
        pick_hit = 1'b1;
        pick_idx = cand;
      end
    end
  end

  // Locked lane is rr_idx until its tlast
  assign cur_idx = lock ? rr_idx : pick_idx;

  always_comb begin
    grant = '0;
    if (lock || pick_hit) begin
      grant[cur_idx] = 1'b1;
    end
  end

  assign load_ok   = !m_tvalid || m_tready;
  assign in_tready = load_ok ? grant : '0;
  assign xfer      = |(in_tvalid & in_tready);
  assign m_tdata   = out_beat.raw;

  always_ff @(posedge axis_aclk or negedge arst_n) begin
    if (!arst_n) begin
      m_tvalid <= 1'b0;
      lock     <= 1'b0;
      rr_idx   <= rp_idx_w'(rp_num - 1);
    end else begin
      if (load_ok) begin
        m_tvalid <= xfer;
      end
      if (xfer) begin
        lock   <= !in_tlast[cur_idx];
        rr_idx <= cur_idx;
      end
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (xfer) begin
      out_beat.raw <= in_tdata[cur_idx*data_w +: data_w];
      m_tlast      <= in_tlast[cur_idx];
    end
  end

  // Grant stays on the same lane until that packet's tlast
  a_grant_lock: assert property (@(posedge axis_aclk) disable iff (!arst_n)
    xfer && !in_tlast[cur_idx] |=> (grant == $past(grant)));

  a_hold_stall: assert property (@(posedge axis_aclk) disable iff (!arst_n)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast));

endmodule

`default_nettype wire

/* verilog/partition_decoupler.sv */
`timescale 1ns/1ps
`default_nettype none

module partition_decoupler (
  input  wire                          axis_aclk,
  input  wire                          arst_n,
  input  wire                          decouple,
  input  wire  [shell_pkg::data_w-1:0] sh_tdata,
  input  wire                          sh_tvalid,
  input  wire                          sh_tlast,
  output logic                         sh_tready,
  output logic [shell_pkg::data_w-1:0] rp_tx_tdata,
  output logic                         rp_tx_tvalid,
  output logic                         rp_tx_tlast,
  input  wire                          rp_tx_tready,
  input  wire  [shell_pkg::data_w-1:0] rp_rx_tdata,
  input  wire                          rp_rx_tvalid,
  input  wire                          rp_rx_tlast,
  output logic                         rp_rx_tready,
  output logic [shell_pkg::data_w-1:0] ret_tdata,
  output logic                         ret_tvalid,
  output logic                         ret_tlast,
  input  wire                          ret_tready
);

  logic tx_busy;
  logic tx_iso;
  logic tx_gap;
  logic rx_busy;
  logic rx_iso;
  logic rx_gap;

  // Toward the partition, isolated beats are dropped
  assign rp_tx_tdata  = sh_tdata;
  assign rp_tx_tlast  = sh_tlast;
  assign rp_tx_tvalid = sh_tvalid && !tx_iso;
  assign sh_tready    = tx_iso || rp_tx_tready;

  // From the partition, isolated traffic is held off
  assign ret_tdata    = rp_rx_tdata;
  assign ret_tlast    = rp_rx_tlast;
  assign ret_tvalid   = rp_rx_tvalid && !rx_iso;
  assign rp_rx_tready = ret_tready && !rx_iso;

  // A gap is a final beat moving or an idle cycle outside a packet
  assign tx_gap = sh_tvalid ? (sh_tready && sh_tlast) : !tx_busy;
  assign rx_gap = ret_tvalid ? (ret_tready && rp_rx_tlast) : !rx_busy;

  always_ff @(posedge axis_aclk or negedge arst_n) begin
    if (!arst_n) begin
      tx_busy <= 1'b0;
      tx_iso  <= 1'b0;
      rx_busy <= 1'b0;
      rx_iso  <= 1'b0;
    end else begin
      if (sh_tvalid && sh_tready) begin
        tx_busy <= !sh_tlast;
      end
      if (tx_gap) begin
        tx_iso <= decouple;
      end
      if (ret_tvalid && ret_tready) begin
        rx_busy <= !rp_rx_tlast;
      end
      if (rx_gap) begin
        rx_iso <= decouple;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/stream_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter int depth = 4
) (
  input  wire                          axis_aclk,
  input  wire                          arst_n,
  input  wire  [shell_pkg::data_w-1:0] in_tdata,
  input  wire                          in_tvalid,
  input  wire                          in_tlast,
  output logic                         in_tready,
  output logic [shell_pkg::data_w-1:0] out_tdata,
  output logic                         out_tvalid,
  output logic                         out_tlast,
  input  wire                          out_tready
);

  import shell_pkg::*;

  // tlast rides in the top bit
  logic [data_w:0]            mem [depth];
  logic [$clog2(depth)-1:0]   wr_ptr;
  logic [$clog2(depth)-1:0]   rd_ptr;
  logic [$clog2(depth):0]     count;
  logic                       wr_en;
  logic                       rd_en;

  assign in_tready  = (count != depth);
  assign out_tvalid = (count != 0);
  assign out_tdata  = mem[rd_ptr][data_w-1:0];
  assign out_tlast  = mem[rd_ptr][data_w];

  assign wr_en = in_tvalid && in_tready;
  assign rd_en = out_tvalid && out_tready;

  always_ff @(posedge axis_aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= {in_tlast, in_tdata};
    end
  end

  always_ff @(posedge axis_aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // Fill level never passes full
  a_no_overflow: assert property (@(posedge axis_aclk) disable iff (!arst_n)
    count <= depth);

endmodule

`default_nettype wire

/* verilog/packet_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_dispatch (
  input  wire                                             axis_aclk,
  input  wire                                             arst_n,
  input  wire  [shell_pkg::data_w-1:0]                    s_tdata,
  input  wire                                             s_tvalid,
  input  wire                                             s_tlast,
  output logic                                            s_tready,
  input  wire  [shell_pkg::rp_num*shell_pkg::port_w-1:0] port_num,
  output logic [shell_pkg::rp_num*shell_pkg::data_w-1:0] lane_tdata,
  output logic [shell_pkg::rp_num-1:0]                   lane_tvalid,
  output logic [shell_pkg::rp_num-1:0]                   lane_tlast,
  input  wire  [shell_pkg::rp_num-1:0]                   lane_tready
);

  import shell_pkg::*;

  beat_u               hdr;
  logic                hdr_hit;
  logic [rp_idx_w-1:0] hdr_idx;
  logic                in_pkt;
  logic                tgt_hit;
  logic [rp_idx_w-1:0] tgt_idx;
  logic                cur_hit;
  logic [rp_idx_w-1:0] cur_idx;

  // Classify the current beat as a header
  // Lowest matching index wins
  always_comb begin
    hdr.raw = s_tdata;
    hdr_hit = 1'b0;
    hdr_idx = '0;
    for (int i = rp_num - 1; i >= 0; i--) begin
      if (hdr.hdr.dest_port == port_num[i*port_w +: port_w]) begin
        hdr_hit = 1'b1;
        hdr_idx = rp_idx_w'(i);
      end
    end
  end

  // Payload beats follow the decision taken on the header
  assign cur_hit = in_pkt ? tgt_hit : hdr_hit;
  assign cur_idx = in_pkt ? tgt_idx : hdr_idx;

  assign lane_tdata = {rp_num{s_tdata}};
  assign lane_tlast = {rp_num{s_tlast}};

  always_comb begin
    lane_tvalid = '0;
    if (s_tvalid && cur_hit) begin
      lane_tvalid[cur_idx] = 1'b1;
    end
  end

  // Unmatched packets are swallowed
  assign s_tready = cur_hit ? lane_tready[cur_idx] : 1'b1;

  always_ff @(posedge axis_aclk or negedge arst_n) begin
    if (!arst_n) begin
      in_pkt  <= 1'b0;
      tgt_hit <= 1'b0;
      tgt_idx <= '0;
    end else if (s_tvalid && s_tready) begin
      if (s_tlast) begin
        in_pkt <= 1'b0;
      end else if (!in_pkt) begin
        in_pkt  <= 1'b1;
        tgt_hit <= hdr_hit;
        tgt_idx <= hdr_idx;
      end
    end
  end

  // All beats of one packet stay on one lane
  a_one_lane: assert property (@(posedge axis_aclk) disable iff (!arst_n)
    s_tvalid && s_tready && !s_tlast |=>
      !s_tvalid || (lane_tvalid == $past(lane_tvalid)));

endmodule

`default_nettype wire

/* verilog/shell_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module shell_regs (
  input  wire                                             axis_aclk,
  input  wire                                             arst_n,
  input  wire                                             cfg_wr,
  input  wire  [regs_pkg::cfg_addr_w-1:0]                 cfg_addr,
  input  wire  [regs_pkg::cfg_data_w-1:0]                 cfg_wdata,
  output logic [shell_pkg::rp_num*shell_pkg::port_w-1:0] port_num,
  output logic [shell_pkg::rp_num-1:0]                   decouple
);

  import shell_pkg::*;
  import regs_pkg::*;

  always_ff @(posedge axis_aclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < rp_num; i++) begin
        port_num[i*port_w +: port_w] <= port_w'(port_base + i);
      end
      decouple <= '0;
    end else if (cfg_wr) begin
      case (cfg_addr)
        addr_port0: port_num[0*port_w +: port_w] <= cfg_wdata;
        addr_port1: port_num[1*port_w +: port_w] <= cfg_wdata;
        addr_port2: port_num[2*port_w +: port_w] <= cfg_wdata;
        addr_port3: port_num[3*port_w +: port_w] <= cfg_wdata;
        // Mask sits in the low bits
        addr_decouple: decouple <= cfg_wdata[rp_num-1:0];
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/regs_pkg.sv */
`default_nettype none

package regs_pkg;

  localparam int cfg_addr_w = 3;
  localparam int cfg_data_w = 16;

  localparam logic [cfg_addr_w-1:0] addr_port0    = 3'd0;
  localparam logic [cfg_addr_w-1:0] addr_port1    = 3'd1;
  localparam logic [cfg_addr_w-1:0] addr_port2    = 3'd2;
  localparam logic [cfg_addr_w-1:0] addr_port3    = 3'd3;
  localparam logic [cfg_addr_w-1:0] addr_decouple = 3'd4;

  // Partition i comes out of reset on port_base + i
  localparam logic [cfg_data_w-1:0] port_base = 16'd4000;

endpackage

`default_nettype wire

/* verilog/shell_pkg.sv */
`default_nettype none

package shell_pkg;

  localparam int data_w   = 32;
  localparam int rp_num   = 4;
  localparam int rp_idx_w = 2;
  localparam int port_w   = 16;
  localparam int tag_w    = 16;

  // First beat of every packet
  typedef struct packed {
    logic [port_w-1:0] dest_port;
    logic [tag_w-1:0]  src_tag;
  } hdr_t;

  // Header beat or payload beat, same 32 bits
  typedef union packed {
    hdr_t              hdr;
    logic [data_w-1:0] raw;
  } beat_u;

endpackage

`default_nettype wire
